// ==== source/nes_io_pkg.sv ====
// Shared widths, counts and button bit positions
// NES button vector type

package nes_io_pkg;

  // Soft-core bus
  localparam int RV_ADDR_W = 23;
  localparam int RV_DATA_W = 32;
  localparam int RV_STRB_W = 4;

  // Half-word memory side
  localparam int MEM_ADDR_W = 20;
  localparam int MEM_DATA_W = 16;
  localparam int MEM_DS_W   = 2;
  localparam int RAM_AW     = 10;   // Decoded half-word address bits

  // Timing
  localparam int RESET_CYCLES    = 255;
  localparam int RESET_CNT_W     = $clog2(RESET_CYCLES + 1);
  localparam int AUTOFIRE_PERIOD = 1024;
  localparam int AUTOFIRE_CNT_W  = $clog2(AUTOFIRE_PERIOD);

  // NES button byte, A is shifted out first
  localparam int BTN_A      = 0;
  localparam int BTN_B      = 1;
  localparam int BTN_SELECT = 2;
  localparam int BTN_START  = 3;
  localparam int BTN_UP     = 4;
  localparam int BTN_DOWN   = 5;
  localparam int BTN_LEFT   = 6;
  localparam int BTN_RIGHT  = 7;

  // Dualshock byte 0, active low
  localparam int DS_SELECT = 0;
  localparam int DS_START  = 3;
  localparam int DS_UP     = 4;
  localparam int DS_RIGHT  = 5;
  localparam int DS_DOWN   = 6;
  localparam int DS_LEFT   = 7;

  // Dualshock byte 1, active low
  localparam int DS_TRIANGLE = 4;
  localparam int DS_CIRCLE   = 5;
  localparam int DS_CROSS    = 6;
  localparam int DS_SQUARE   = 7;

  typedef logic [7:0] nes_btn_t;   // Active high

endpackage

// ==== source/mem16_if.sv ====
// Half-word memory request interface
// Toggle req/ack handshake, bridge and RAM modports

`timescale 1ns/1ps

interface mem16_if import nes_io_pkg::*; ();

  logic                  req;    // Inverted for each new request
  logic                  ack;    // Follows req on completion
  logic [MEM_ADDR_W-1:0] addr;
  logic                  we;
  logic [MEM_DS_W-1:0]   ds;     // Byte selects
  logic [MEM_DATA_W-1:0] din;
  logic [MEM_DATA_W-1:0] dout;

  modport bridge (
    output req, addr, we, ds, din,
    input  ack, dout
  );

  modport ram (
    input  req, addr, we, ds, din,
    output ack, dout
  );

endinterface

// ==== source/autofire.sv ====
// Autofire square wave for one held button

`timescale 1ns/1ps

module autofire import nes_io_pkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic i_held,
  output logic o_fire
);

  logic [AUTOFIRE_CNT_W-1:0] period_cnt;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      period_cnt <= '0;
      o_fire     <= 1'b0;
    end else if (!i_held) begin
      period_cnt <= '0;   // Release restarts the pattern
      o_fire     <= 1'b0;
    end else begin
      if (period_cnt == '0)
        o_fire <= ~o_fire;   // First press and every wrap
      if (period_cnt == AUTOFIRE_CNT_W'(AUTOFIRE_PERIOD - 1))
        period_cnt <= '0;
      else
        period_cnt <= period_cnt + 1'b1;
    end
  end

endmodule

// ==== source/reset_gen.sv ====
// System reset generator
// Start-up hold, reset button and Select+Down home combination

`timescale 1ns/1ps

module reset_gen import nes_io_pkg::*; (
  input  logic     clk,
  input  logic     resetn,
  input  logic     i_reset_btn,
  input  nes_btn_t i_p1_btn,
  output logic     o_sys_resetn
);

  logic [RESET_CNT_W-1:0] hold_cnt;
  logic                   home_combo;

  assign home_combo = i_p1_btn[BTN_SELECT] & i_p1_btn[BTN_DOWN];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      hold_cnt     <= RESET_CNT_W'(RESET_CYCLES);
      o_sys_resetn <= 1'b0;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;   // Still in start-up hold
    end else begin
      o_sys_resetn <= ~i_reset_btn & ~home_combo;
    end
  end

endmodule

// ==== source/pad_mapper.sv ====
// Dualshock to NES button mapping for one player
// Autofire on square (B) and triangle (A)

`timescale 1ns/1ps

module pad_mapper import nes_io_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  logic [7:0] i_ds_b0,   // Active low
  input  logic [7:0] i_ds_b1,   // Active low
  output nes_btn_t   o_btn
);

  logic auto_square;
  logic auto_triangle;

  autofire u_af_square (
    .clk    (clk),
    .resetn (resetn),
    .i_held (~i_ds_b1[DS_SQUARE]),
    .o_fire (auto_square)
  );

  autofire u_af_triangle (
    .clk    (clk),
    .resetn (resetn),
    .i_held (~i_ds_b1[DS_TRIANGLE]),
    .o_fire (auto_triangle)
  );

  always_comb begin
    o_btn[BTN_RIGHT]  = ~i_ds_b0[DS_RIGHT];
    o_btn[BTN_LEFT]   = ~i_ds_b0[DS_LEFT];
    o_btn[BTN_DOWN]   = ~i_ds_b0[DS_DOWN];
    o_btn[BTN_UP]     = ~i_ds_b0[DS_UP];
    o_btn[BTN_START]  = ~i_ds_b0[DS_START];
    o_btn[BTN_SELECT] = ~i_ds_b0[DS_SELECT];

    // Cross is B, circle is A
    o_btn[BTN_B] = ~i_ds_b1[DS_CROSS] | auto_square;
    o_btn[BTN_A] = ~i_ds_b1[DS_CIRCLE] | auto_triangle;
  end

endmodule

// ==== source/joypad_port.sv ====
// NES serial joypad shift register for one player
// Level strobe loads, falling clock edge shifts

`timescale 1ns/1ps

module joypad_port import nes_io_pkg::*; (
  input  logic     clk,
  input  logic     resetn,
  input  nes_btn_t i_btn,
  input  logic     i_strobe,
  input  logic     i_clock,
  output logic     o_data
);

  logic     clock_r;
  nes_btn_t shift_q;
  logic     clock_fall;

  assign clock_fall = clock_r & ~i_clock;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      clock_r <= 1'b0;
      shift_q <= '0;
    end else begin
      clock_r <= i_clock;
      if (i_strobe)
        shift_q <= i_btn;   // Strobe wins over a clock edge
      else if (clock_fall)
        shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  // Serial data is the low bit, A first
  assign o_data = shift_q[0];

endmodule

// ==== source/rv_bridge.sv ====
// Soft-core 32-bit bus to 16-bit toggle handshake bridge
// Read is two half-word requests, writes skip untouched halves

`timescale 1ns/1ps

module rv_bridge import nes_io_pkg::*; (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 i_valid,
  input  logic [RV_ADDR_W-1:0] i_addr,
  input  logic [RV_DATA_W-1:0] i_wdata,
  input  logic [RV_STRB_W-1:0] i_wstrb,
  output logic                 o_ready,
  output logic [RV_DATA_W-1:0] o_rdata,
  mem16_if.bridge              mem
);

  typedef enum logic [2:0] {
    S_IDLE_REQ0,
    S_WAIT0_REQ1,
    S_DATA0,
    S_WAIT1,
    S_DATA1
  } state_t;

  state_t              state;
  logic                valid_r;
  logic                new_req;      // Rising edge seen while busy
  logic                valid_rise;
  logic                is_write;
  logic                word;         // Active half-word
  logic                req;
  logic [MEM_DS_W-1:0] ds;
  logic [MEM_DS_W-1:0] strb_lo;
  logic [MEM_DS_W-1:0] strb_hi;
  logic                done;

  assign valid_rise = i_valid & ~valid_r;
  assign is_write   = i_wstrb != '0;
  assign strb_lo    = i_wstrb[MEM_DS_W-1:0];
  assign strb_hi    = i_wstrb[RV_STRB_W-1:MEM_DS_W];
  assign done       = req == mem.ack;

  // Request fields follow the bus inputs, which hold until o_ready
  assign mem.req  = req;
  assign mem.we   = is_write;
  assign mem.ds   = ds;
  assign mem.addr = {i_addr[MEM_ADDR_W:2], word};
  assign mem.din  = word ? i_wdata[RV_DATA_W-1:MEM_DATA_W] : i_wdata[MEM_DATA_W-1:0];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state   <= S_IDLE_REQ0;
      valid_r <= 1'b0;
      new_req <= 1'b0;
      word    <= 1'b0;
      req     <= 1'b0;
      ds      <= '0;
      o_ready <= 1'b0;
    end else begin
      valid_r <= i_valid;
      o_ready <= 1'b0;
      if (valid_rise)
        new_req <= 1'b1;

      case (state)
        S_IDLE_REQ0: if (new_req || valid_rise) begin
          new_req <= 1'b0;
          req     <= ~req;
          if (is_write && strb_lo == '0) begin
            word  <= 1'b1;   // Upper half only
            ds    <= strb_hi;
            state <= S_WAIT1;
          end else begin
            word  <= 1'b0;
            ds    <= is_write ? strb_lo : '1;
            state <= S_WAIT0_REQ1;
          end
        end

        S_WAIT0_REQ1: if (done) begin
          if (is_write && strb_hi == '0) begin
            o_ready <= 1'b1;   // Lower half only
            state   <= S_IDLE_REQ0;
          end else begin
            req   <= ~req;     // Request 1
            word  <= 1'b1;
            ds    <= is_write ? strb_hi : '1;
            state <= is_write ? S_WAIT1 : S_DATA0;
          end
        end

        // RAM still shows half 0 here
        S_DATA0: begin
          o_rdata[MEM_DATA_W-1:0] <= mem.dout;
          state                   <= S_WAIT1;
        end

        S_WAIT1: if (done) begin
          if (is_write) begin
            o_ready <= 1'b1;
            state   <= S_IDLE_REQ0;
          end else begin
            state <= S_DATA1;
          end
        end

        S_DATA1: begin
          o_rdata[RV_DATA_W-1:MEM_DATA_W] <= mem.dout;
          o_ready                         <= 1'b1;
          state                           <= S_IDLE_REQ0;
        end

        default: state <= S_IDLE_REQ0;
      endcase
    end
  end

endmodule

// ==== source/word_ram.sv ====
// Byte-writable half-word RAM on the toggle handshake
// Answers one cycle after a request is seen, upper addresses alias

`timescale 1ns/1ps

module word_ram import nes_io_pkg::*; (
  input  logic  clk,
  input  logic  resetn,
  mem16_if.ram  mem
);

  logic [MEM_DATA_W-1:0] ram_q [2**RAM_AW];
  logic [RAM_AW-1:0]     idx;
  logic                  ack_q;
  logic [MEM_DATA_W-1:0] dout_q;
  logic                  pending;

  assign idx     = mem.addr[RAM_AW-1:0];
  assign pending = mem.req != ack_q;

  always_ff @(posedge clk) begin
    if (!resetn)
      ack_q <= 1'b0;
    else if (pending)
      ack_q <= mem.req;   // Completes the request
  end

  always_ff @(posedge clk) begin
    if (pending) begin
      if (mem.we) begin
        for (int b = 0; b < MEM_DS_W; b++) begin
          if (mem.ds[b])
            ram_q[idx][b*8 +: 8] <= mem.din[b*8 +: 8];
        end
      end else begin
        dout_q <= ram_q[idx];   // Held until the next read
      end
    end
  end

  assign mem.ack  = ack_q;
  assign mem.dout = dout_q;

endmodule

// ==== source/nes_io_top.sv ====
// Controller and memory side of the console top level
// Reset generator, two pad paths with joypad ports, bridge and RAM

`timescale 1ns/1ps

module nes_io_top import nes_io_pkg::*; (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 i_reset_btn,
  input  logic [7:0]           i_ds1_b0,
  input  logic [7:0]           i_ds1_b1,
  input  logic [7:0]           i_ds2_b0,
  input  logic [7:0]           i_ds2_b1,
  input  logic                 i_joy_strobe,
  input  logic [1:0]           i_joy_clock,
  input  logic                 i_rv_valid,
  input  logic [RV_ADDR_W-1:0] i_rv_addr,
  input  logic [RV_DATA_W-1:0] i_rv_wdata,
  input  logic [RV_STRB_W-1:0] i_rv_wstrb,
  output logic                 o_sys_resetn,
  output logic [1:0]           o_joy_data,
  output logic                 o_rv_ready,
  output logic [RV_DATA_W-1:0] o_rv_rdata
);

  logic     sys_resetn;
  nes_btn_t p1_btn;
  nes_btn_t p2_btn;

  mem16_if u_mem16 ();

  // Home combination is watched on player 1 only
  reset_gen u_reset_gen (
    .clk          (clk),
    .resetn       (resetn),
    .i_reset_btn  (i_reset_btn),
    .i_p1_btn     (p1_btn),
    .o_sys_resetn (sys_resetn)
  );

  assign o_sys_resetn = sys_resetn;

  pad_mapper u_pad1 (
    .clk     (clk),
    .resetn  (sys_resetn),
    .i_ds_b0 (i_ds1_b0),
    .i_ds_b1 (i_ds1_b1),
    .o_btn   (p1_btn)
  );

  pad_mapper u_pad2 (
    .clk     (clk),
    .resetn  (sys_resetn),
    .i_ds_b0 (i_ds2_b0),
    .i_ds_b1 (i_ds2_b1),
    .o_btn   (p2_btn)
  );

  joypad_port u_joy1 (
    .clk      (clk),
    .resetn   (sys_resetn),
    .i_btn    (p1_btn),
    .i_strobe (i_joy_strobe),   // Shared latch for both ports
    .i_clock  (i_joy_clock[0]),
    .o_data   (o_joy_data[0])
  );

  joypad_port u_joy2 (
    .clk      (clk),
    .resetn   (sys_resetn),
    .i_btn    (p2_btn),
    .i_strobe (i_joy_strobe),
    .i_clock  (i_joy_clock[1]),
    .o_data   (o_joy_data[1])
  );

  rv_bridge u_bridge (
    .clk     (clk),
    .resetn  (sys_resetn),
    .i_valid (i_rv_valid),
    .i_addr  (i_rv_addr),
    .i_wdata (i_rv_wdata),
    .i_wstrb (i_rv_wstrb),
    .o_ready (o_rv_ready),
    .o_rdata (o_rv_rdata),
    .mem     (u_mem16.bridge)
  );

  word_ram u_ram (
    .clk    (clk),
    .resetn (sys_resetn),
    .mem    (u_mem16.ram)
  );

endmodule

// ==== tb/nes_io_chk.sv ====
// Bridge handshake assertions, bound into rv_bridge
// Single-cycle ready, stable toggle while pending, byte selects on writes

`timescale 1ns/1ps

module nes_io_chk import nes_io_pkg::*; (
  input logic                clk,
  input logic                resetn,
  input logic                i_ready,
  input logic                i_req,
  input logic                i_done,
  input logic                i_we,
  input logic [MEM_DS_W-1:0] i_ds
);

  ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
    i_ready |=> !i_ready)
    else $error("o_ready high for two cycles");

  // No new toggle until ack has caught up
  req_hold: assert property (@(posedge clk) disable iff (!resetn)
    !i_done |=> $stable(i_req))
    else $error("req toggled while a request was pending");

  write_ds: assert property (@(posedge clk) disable iff (!resetn)
    (!i_done && i_we) |-> i_ds != '0)
    else $error("write request with no byte selected");

endmodule

bind rv_bridge nes_io_chk u_chk (
  .clk     (clk),
  .resetn  (resetn),
  .i_ready (o_ready),
  .i_req   (req),
  .i_done  (done),
  .i_we    (is_write),
  .i_ds    (ds)
);

// ==== tb/tb_nes_io.sv ====
// Testbench for the controller and memory top level
// Reset release, joypad mapping, autofire and 32-bit bus tests
// Bus tests keep a reference model of the RAM words

`timescale 1ns/1ps

module tb_nes_io import nes_io_pkg::*; ();

  localparam int N_WORDS        = 16;
  localparam int READY_LIMIT    = 32;
  localparam int N_TESTS        = 4;
  localparam int TIMEOUT_CYCLES = N_TESTS * 6 * AUTOFIRE_PERIOD;   // Autofire test is longest

  logic                 clk, resetn, i_reset_btn, i_joy_strobe, i_rv_valid;
  logic [7:0]           i_ds1_b0, i_ds1_b1, i_ds2_b0, i_ds2_b1;
  logic [1:0]           i_joy_clock, o_joy_data;
  logic [RV_ADDR_W-1:0] i_rv_addr;
  logic [RV_DATA_W-1:0] i_rv_wdata, o_rv_rdata;
  logic [RV_STRB_W-1:0] i_rv_wstrb;
  logic                 o_sys_resetn, o_rv_ready;
  logic [31:0]          model [512];   // Indexed by byte address bits 10:2
  logic [3:0]           strbs [6] = '{4'b0011, 4'b1100, 4'b0001, 4'b0010, 4'b0100, 4'b1000};
  int                   seed = 32'h75b9_841d;

  nes_io_top i_nes_io_top (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;   // 20 ns period

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("Test failures found");
      $fatal(1, "stopped at first error");
    end
  endtask

  // NES order right down to A, from active-low Dualshock bits, autofire idle
  function automatic nes_btn_t map_buttons(input logic [7:0] b0, input logic [7:0] b1);
    return ~{b0[DS_RIGHT], b0[DS_LEFT], b0[DS_DOWN], b0[DS_UP], b0[DS_START],
             b0[DS_SELECT], b1[DS_CROSS], b1[DS_CIRCLE]};
  endfunction

  task automatic wait_sys_reset(input int min_cycles, input int max_cycles);
    int n;
    n = 0;
    while (!o_sys_resetn && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    check(32'(o_sys_resetn), 32'd1, "system reset not released in time");
    check(32'(n >= min_cycles), 32'd1, "system reset released too early");
  endtask

  // Strobe, then eight clocks on both ports, A comes first
  task automatic pad_read(output logic [7:0] got1, output logic [7:0] got2);
    int i;
    i_joy_strobe = 1'b1;
    @(negedge clk);
    i_joy_strobe = 1'b0;
    for (i = 0; i < 8; i++) begin
      got1[i] = o_joy_data[0];
      got2[i] = o_joy_data[1];
      i_joy_clock = 2'b11;
      @(negedge clk);
      i_joy_clock = 2'b00;
      @(negedge clk);
    end
    check(32'(o_joy_data), 32'd0, "zero fill after eight bits");
  endtask

  task automatic bus_cycle(input logic [RV_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int n;
    i_rv_addr  = addr;
    i_rv_wdata = data;
    i_rv_wstrb = strb;
    i_rv_valid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!o_rv_ready && n < READY_LIMIT);
    check(32'(o_rv_ready), 32'd1, "no o_rv_ready within limit");
    i_rv_valid = 1'b0;
    @(negedge clk);   // Valid low for a cycle before the next request
  endtask

  task automatic rv_write(input logic [RV_ADDR_W-1:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    int b;
    bus_cycle(addr, data, strb);
    for (b = 0; b < 4; b++) begin
      if (strb[b])
        model[addr[10:2]][b*8 +: 8] = data[b*8 +: 8];
    end
  endtask

  task automatic rv_read(input logic [RV_ADDR_W-1:0] addr);
    bus_cycle(addr, 32'h0, 4'h0);
    check(o_rv_rdata, model[addr[10:2]], "read data");
  endtask

  task automatic reset_release();
    wait_sys_reset(RESET_CYCLES, RESET_CYCLES + 2);
    i_reset_btn = 1'b1;
    repeat (2) @(negedge clk);
    check(32'(o_sys_resetn), 32'd0, "reset button");
    i_reset_btn = 1'b0;
    wait_sys_reset(1, 2);
    i_ds1_b0 = 8'hBE;   // Select and down held
    repeat (2) @(negedge clk);
    check(32'(o_sys_resetn), 32'd0, "home combination");
    i_ds1_b0 = 8'hFF;
    wait_sys_reset(1, 2);
  endtask

  task automatic button_mapping();
    logic [31:0] r;
    logic [7:0]  g1, g2;
    int          k;
    for (k = 0; k < 4; k++) begin
      r = $random(seed);
      i_ds1_b0 = r[7:0] | 8'h01;     // Select up, so never the home combination
      i_ds1_b1 = r[15:8] | 8'h90;    // Square and triangle up
      i_ds2_b0 = r[23:16];
      i_ds2_b1 = r[31:24] | 8'h90;
      pad_read(g1, g2);
      check(32'(g1), 32'(map_buttons(i_ds1_b0, i_ds1_b1)), "player 1 buttons");
      check(32'(g2), 32'(map_buttons(i_ds2_b0, i_ds2_b1)), "player 2 buttons");
    end
  endtask

  task automatic autofire_toggle();
    logic [7:0] g1, g2;
    logic [1:0] seen_b, seen_a;
    int         k;
    i_ds1_b0 = 8'hFF;
    i_ds2_b0 = 8'hFF;
    i_ds1_b1 = 8'h7F;   // Square held on player 1
    i_ds2_b1 = 8'hEF;   // Triangle held on player 2
    seen_b = '0;
    seen_a = '0;
    @(negedge clk);     // Autofire running before the first read
    for (k = 0; k < 4; k++) begin
      pad_read(g1, g2);
      seen_b[g1[BTN_B]] = 1'b1;
      seen_a[g2[BTN_A]] = 1'b1;
      repeat (AUTOFIRE_PERIOD) @(negedge clk);
    end
    check(32'({seen_b, seen_a}), 32'hF, "autofire levels on B and A");
    i_ds1_b1 = 8'hFF;
    i_ds2_b1 = 8'hFF;
    repeat (AUTOFIRE_PERIOD) @(negedge clk);
    pad_read(g1, g2);
    check(32'({g1, g2}), 32'd0, "buttons after autofire release");
  endtask

  // Full words to random addresses, then partial writes over the same words
  task automatic memory_words();
    logic [RV_ADDR_W-1:0] addrs [N_WORDS];
    logic [31:0]          r;
    int                   k;
    for (k = 0; k < N_WORDS; k++) begin
      r = $random(seed);
      addrs[k] = RV_ADDR_W'({r[8:0], 2'b00});   // Inside the decoded RAM
      rv_write(addrs[k], $random(seed), 4'hF);
    end
    for (k = 0; k < N_WORDS; k++)
      rv_read(addrs[k]);
    for (k = 0; k < N_WORDS; k++) begin
      rv_write(addrs[k], $random(seed), strbs[k % 6]);
      rv_read(addrs[k]);
    end
  endtask

  initial begin
    resetn = 1'b0;
    {i_reset_btn, i_joy_strobe, i_joy_clock, i_rv_valid} = '0;
    {i_ds1_b0, i_ds1_b1, i_ds2_b0, i_ds2_b1} = '1;   // All buttons up
    {i_rv_addr, i_rv_wdata, i_rv_wstrb} = '0;
    repeat (10) @(negedge clk);
    resetn = 1'b1;
    reset_release();
    button_mapping();
    autofire_toggle();
    memory_words();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== files.f ====
source/nes_io_pkg.sv
source/mem16_if.sv
source/autofire.sv
source/reset_gen.sv
source/pad_mapper.sv
source/joypad_port.sv
source/rv_bridge.sv
source/word_ram.sv
source/nes_io_top.sv
tb/nes_io_chk.sv
tb/tb_nes_io.sv

// ==== Makefile ====
TOP := tb_nes_io

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
